// ==== Bender.yml ====
package:
  name: bomber

sources:
  - files:
      - source/bomber_pkg.sv
      - source/arena_map.sv
      - source/player_ctrl.sv
      - source/bubble_slots.sv
      - source/blast_spread.sv
      - source/apb_regs.sv
      - source/bomber_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_bomber.sv

// ==== source/apb_regs.sv ====
`timescale 1ns/1ns

module apb_regs
	import bomber_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [11:0]      paddr_i,
	input  logic             psel_i,
	input  logic             penable_i,
	input  logic             pwrite_i,
	input  logic [31:0]      pwdata_i,
	output logic [31:0]      prdata_o,
	output logic             pready_o,
	output logic             pslverr_o,
	input  logic [COL_W-1:0] p1_col_i,
	input  logic [ROW_W-1:0] p1_row_i,
	input  logic [COL_W-1:0] p2_col_i,
	input  logic [ROW_W-1:0] p2_row_i,
	input  logic             p1_dead_i,
	input  logic             p2_dead_i,
	input  cell_t            rd_cell_i,
	output logic [IDX_W-1:0] rd_idx_o,
	output cmd_op_t          cmd_op_o,
	output logic             p1_cmd_valid_o,
	output logic             p2_cmd_valid_o
);

	logic        access;
	logic        in_map;
	logic        addr_err;
	logic [11:0] map_off;
	logic [31:0] rd_data;

	assign access   = psel_i & penable_i;
	assign pready_o = 1'b1;

	// map window, one word per cell
	assign map_off  = paddr_i - ADDR_MAP_BASE;
	assign in_map   = paddr_i >= ADDR_MAP_BASE && paddr_i[1:0] == 2'b00 &&
	                  paddr_i < ADDR_MAP_BASE + 12'(4 * CELL_COUNT);
	assign rd_idx_o = map_off[IDX_W+1:2];

	always_comb begin
		rd_data  = '0;
		addr_err = 1'b0;
		case (paddr_i)
			ADDR_CMD:    addr_err = !pwrite_i;
			ADDR_STATUS: begin
				rd_data  = {30'd0, p2_dead_i, p1_dead_i};
				addr_err = pwrite_i;
			end
			ADDR_P1_POS: begin
				rd_data  = {20'd0, p1_row_i, 4'd0, p1_col_i};
				addr_err = pwrite_i;
			end
			ADDR_P2_POS: begin
				rd_data  = {20'd0, p2_row_i, 4'd0, p2_col_i};
				addr_err = pwrite_i;
			end
			default: begin
				rd_data  = {29'd0, rd_cell_i};
				addr_err = pwrite_i || !in_map;
			end
		endcase
	end

	assign prdata_o  = (access && !pwrite_i) ? rd_data : '0;
	assign pslverr_o = access & addr_err;

	// one-cycle command pulse, bit 4 picks player 2
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cmd_op_o       <= OP_UP;
			p1_cmd_valid_o <= 1'b0;
			p2_cmd_valid_o <= 1'b0;
		end else begin
			p1_cmd_valid_o <= 1'b0;
			p2_cmd_valid_o <= 1'b0;
			if (access && pwrite_i && paddr_i == ADDR_CMD) begin
				cmd_op_o       <= cmd_op_t'(pwdata_i[2:0]);
				p1_cmd_valid_o <= !pwdata_i[4];
				p2_cmd_valid_o <= pwdata_i[4];
			end
		end
	end

	// access phase always follows a setup phase
	assert property (@(posedge clk) disable iff (rst) penable_i |-> psel_i && $past(psel_i))
		else $error("penable_i without a setup phase");

endmodule

// ==== source/arena_map.sv ====
`timescale 1ns/1ns

module arena_map
	import bomber_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [CELL_COUNT-1:0] box_clear_i,
	input  logic [CELL_COUNT-1:0] bubble_cells_i,
	input  logic [CELL_COUNT-1:0] blast_cells_i,
	input  logic [IDX_W-1:0]      p1_target_idx_i,
	input  logic [IDX_W-1:0]      p2_target_idx_i,
	input  logic [IDX_W-1:0]      rd_idx_i,
	output cell_t                 p1_target_cell_o,
	output cell_t                 p2_target_cell_o,
	output cell_t                 rd_cell_o,
	output logic [CELL_COUNT-1:0] terrain_wall_o,
	output logic [CELL_COUNT-1:0] terrain_box_o
);

	cell_t terrain [CELL_COUNT];
	cell_t view [CELL_COUNT];

	// fixed start layout
	function automatic cell_t layout_cell(input int row, input int col);
		if (row[0] && col[0])
			return CELL_WALL;
		else if (col == 5 || col == 6)
			return CELL_BOX;
		else
			return CELL_FLOOR;
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int r = 0; r < GRID_H; r++)
				for (int c = 0; c < GRID_W; c++)
					terrain[r * GRID_W + c] <= layout_cell(r, c);
		end else begin
			for (int n = 0; n < CELL_COUNT; n++)
				if (box_clear_i[n])
					terrain[n] <= CELL_FLOOR;
		end
	end

	// blast beats bubble beats terrain
	for (genvar n = 0; n < CELL_COUNT; n++) begin : g_cell
		assign terrain_wall_o[n] = (terrain[n] == CELL_WALL);
		assign terrain_box_o[n]  = (terrain[n] == CELL_BOX);
		assign view[n] = blast_cells_i[n]  ? CELL_BLAST :
		                 bubble_cells_i[n] ? CELL_BUBBLE : terrain[n];
	end

	// indexes past the grid look like wall
	always_comb begin
		p1_target_cell_o = (p1_target_idx_i < CELL_COUNT) ? view[p1_target_idx_i] : CELL_WALL;
		p2_target_cell_o = (p2_target_idx_i < CELL_COUNT) ? view[p2_target_idx_i] : CELL_WALL;
		rd_cell_o        = (rd_idx_i < CELL_COUNT) ? view[rd_idx_i] : CELL_WALL;
	end

	// walls stop every blast walk, so none is ever cleared
	assert property (@(posedge clk) disable iff (rst) (box_clear_i & terrain_wall_o) == '0)
		else $error("box_clear_i marks a wall cell");

endmodule

// ==== source/blast_spread.sv ====
`timescale 1ns/1ns

module blast_spread
	import bomber_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic [SLOTS-1:0]            burst_mask_i,
	input  logic [SLOTS-1:0][IDX_W-1:0] slot_idx_i,
	input  logic [CELL_COUNT-1:0]       terrain_wall_i,
	input  logic [CELL_COUNT-1:0]       terrain_box_i,
	output logic [CELL_COUNT-1:0]       blast_cells_o,
	output logic [CELL_COUNT-1:0]       box_clear_o
);

	logic [CELL_COUNT-1:0] walk_blast [SLOTS];
	logic [CELL_COUNT-1:0] walk_clear [SLOTS];
	logic [CELL_COUNT-1:0] held_blast [SLOTS];
	logic [CELL_COUNT-1:0] held_clear [SLOTS];

	// cross walk from each slot cell
	always_comb begin
		int c;
		int r;
		int nc;
		int nr;
		int n;
		logic go;
		for (int s = 0; s < SLOTS; s++) begin
			walk_blast[s] = '0;
			walk_clear[s] = '0;
			c = slot_idx_i[s] % GRID_W;
			r = slot_idx_i[s] / GRID_W;
			walk_blast[s][slot_idx_i[s]] = 1'b1;
			for (int d = 0; d < 4; d++) begin
				go = 1'b1;
				for (int k = 1; k <= BLAST_RANGE; k++) begin
					nc = c;
					nr = r;
					case (d)
						0:       nr = r - k;
						1:       nr = r + k;
						2:       nc = c - k;
						default: nc = c + k;
					endcase
					if (go && nc >= 0 && nc < GRID_W && nr >= 0 && nr < GRID_H) begin
						n = nr * GRID_W + nc;
						if (terrain_wall_i[n]) begin
							go = 1'b0;
						end else begin
							walk_blast[s][n] = 1'b1;
							// first box ends the arm
							if (terrain_box_i[n]) begin
								walk_clear[s][n] = 1'b1;
								go = 1'b0;
							end
						end
					end else begin
						go = 1'b0;
					end
				end
			end
		end
	end

	// shape is frozen at burst so a cleared box does not extend the arm
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int s = 0; s < SLOTS; s++) begin
				held_blast[s] <= '0;
				held_clear[s] <= '0;
			end
		end else begin
			for (int s = 0; s < SLOTS; s++) begin
				if (!burst_mask_i[s]) begin
					held_blast[s] <= '0;
					held_clear[s] <= '0;
				end else if (held_blast[s] == '0) begin
					held_blast[s] <= walk_blast[s];
					held_clear[s] <= walk_clear[s];
				end
			end
		end
	end

	always_comb begin
		blast_cells_o = '0;
		box_clear_o   = '0;
		for (int s = 0; s < SLOTS; s++) begin
			blast_cells_o = blast_cells_o | held_blast[s];
			box_clear_o   = box_clear_o | held_clear[s];
		end
	end

endmodule

// ==== source/bomber_pkg.sv ====
package bomber_pkg;

	// ----------------------------------------
	// arena grid
	// ----------------------------------------
	localparam int GRID_W     = 12;
	localparam int GRID_H     = 9;
	localparam int CELL_COUNT = 108;
	localparam int COL_W      = 4;
	localparam int ROW_W      = 4;
	localparam int IDX_W      = 7;

	// ----------------------------------------
	// game timing
	// ----------------------------------------
	// slots 0,1 for player 1 and slots 2,3 for player 2
	localparam int SLOTS        = 4;
	localparam int BLAST_RANGE  = 2;
	localparam int FUSE_CYCLES  = 64;
	localparam int BLAST_CYCLES = 16;
	localparam int DEAD_CYCLES  = 4;
	localparam int TIMER_W      = 7;

	typedef enum logic [2:0] {
		CELL_FLOOR,
		CELL_WALL,
		CELL_BOX,
		CELL_BUBBLE,
		CELL_BLAST
	} cell_t;

	// up lowers the row, left lowers the column
	typedef enum logic [2:0] {
		OP_UP,
		OP_DOWN,
		OP_LEFT,
		OP_RIGHT,
		OP_BUBBLE
	} cmd_op_t;

	typedef enum logic [1:0] {
		SLOT_IDLE,
		SLOT_FUSE,
		SLOT_BLAST
	} slot_state_t;

	// apb byte addresses
	localparam logic [11:0] ADDR_CMD      = 12'h000;
	localparam logic [11:0] ADDR_STATUS   = 12'h004;
	localparam logic [11:0] ADDR_P1_POS   = 12'h008;
	localparam logic [11:0] ADDR_P2_POS   = 12'h00C;
	localparam logic [11:0] ADDR_MAP_BASE = 12'h100;

endpackage

// ==== source/bomber_top.sv ====
`timescale 1ns/1ns

module bomber_top
	import bomber_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [11:0] paddr_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        pslverr_o
);

	cmd_op_t                     cmd_op;
	logic                        p1_cmd_valid;
	logic                        p2_cmd_valid;
	cell_t                       p1_target_cell;
	cell_t                       p2_target_cell;
	cell_t                       rd_cell;
	logic [IDX_W-1:0]            p1_target_idx;
	logic [IDX_W-1:0]            p2_target_idx;
	logic [IDX_W-1:0]            p1_cell_idx;
	logic [IDX_W-1:0]            p2_cell_idx;
	logic [IDX_W-1:0]            rd_idx;
	logic [COL_W-1:0]            p1_col;
	logic [COL_W-1:0]            p2_col;
	logic [ROW_W-1:0]            p1_row;
	logic [ROW_W-1:0]            p2_row;
	logic                        p1_bubble_req;
	logic                        p2_bubble_req;
	logic                        p1_dead;
	logic                        p2_dead;
	logic [SLOTS-1:0]            burst_mask;
	logic [SLOTS-1:0][IDX_W-1:0] slot_idx;
	logic [CELL_COUNT-1:0]       bubble_cells;
	logic [CELL_COUNT-1:0]       blast_cells;
	logic [CELL_COUNT-1:0]       box_clear;
	logic [CELL_COUNT-1:0]       terrain_wall;
	logic [CELL_COUNT-1:0]       terrain_box;

	arena_map u_arena_map (
		.clk, .rst,
		.box_clear_i(box_clear), .bubble_cells_i(bubble_cells), .blast_cells_i(blast_cells),
		.p1_target_idx_i(p1_target_idx), .p2_target_idx_i(p2_target_idx), .rd_idx_i(rd_idx),
		.p1_target_cell_o(p1_target_cell), .p2_target_cell_o(p2_target_cell),
		.rd_cell_o(rd_cell), .terrain_wall_o(terrain_wall), .terrain_box_o(terrain_box)
	);

	player_ctrl #(.START_COL(0), .START_ROW(0)) u_player1 (
		.clk, .rst, .cmd_valid_i(p1_cmd_valid), .cmd_op_i(cmd_op),
		.target_cell_i(p1_target_cell), .in_blast_i(blast_cells[p1_cell_idx]),
		.target_idx_o(p1_target_idx), .cell_idx_o(p1_cell_idx), .col_o(p1_col),
		.row_o(p1_row), .bubble_req_o(p1_bubble_req), .dead_o(p1_dead)
	);

	player_ctrl #(.START_COL(GRID_W - 1), .START_ROW(GRID_H - 1)) u_player2 (
		.clk, .rst, .cmd_valid_i(p2_cmd_valid), .cmd_op_i(cmd_op),
		.target_cell_i(p2_target_cell), .in_blast_i(blast_cells[p2_cell_idx]),
		.target_idx_o(p2_target_idx), .cell_idx_o(p2_cell_idx), .col_o(p2_col),
		.row_o(p2_row), .bubble_req_o(p2_bubble_req), .dead_o(p2_dead)
	);

	bubble_slots u_bubble_slots (
		.clk, .rst, .p1_req_i(p1_bubble_req), .p2_req_i(p2_bubble_req),
		.p1_idx_i(p1_cell_idx), .p2_idx_i(p2_cell_idx), .blast_cells_i(blast_cells),
		.burst_mask_o(burst_mask), .slot_idx_o(slot_idx), .bubble_cells_o(bubble_cells)
	);

	blast_spread u_blast_spread (
		.clk, .rst, .burst_mask_i(burst_mask), .slot_idx_i(slot_idx),
		.terrain_wall_i(terrain_wall), .terrain_box_i(terrain_box),
		.blast_cells_o(blast_cells), .box_clear_o(box_clear)
	);

	apb_regs u_apb_regs (
		.clk, .rst, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
		.prdata_o, .pready_o, .pslverr_o,
		.p1_col_i(p1_col), .p1_row_i(p1_row), .p2_col_i(p2_col), .p2_row_i(p2_row),
		.p1_dead_i(p1_dead), .p2_dead_i(p2_dead), .rd_cell_i(rd_cell), .rd_idx_o(rd_idx),
		.cmd_op_o(cmd_op), .p1_cmd_valid_o(p1_cmd_valid), .p2_cmd_valid_o(p2_cmd_valid)
	);

endmodule

// ==== source/bubble_slots.sv ====
`timescale 1ns/1ns

module bubble_slots
	import bomber_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         p1_req_i,
	input  logic                         p2_req_i,
	input  logic [IDX_W-1:0]             p1_idx_i,
	input  logic [IDX_W-1:0]             p2_idx_i,
	input  logic [CELL_COUNT-1:0]        blast_cells_i,
	output logic [SLOTS-1:0]             burst_mask_o,
	output logic [SLOTS-1:0][IDX_W-1:0]  slot_idx_o,
	output logic [CELL_COUNT-1:0]        bubble_cells_o
);

	slot_state_t        state [SLOTS];
	logic [TIMER_W-1:0] timer [SLOTS];
	logic [SLOTS-1:0]   grant;
	logic               p1_grant;

	// cells held by a live slot, fusing or bursting
	always_comb begin
		bubble_cells_o = '0;
		for (int s = 0; s < SLOTS; s++) begin
			burst_mask_o[s] = (state[s] == SLOT_BLAST);
			if (state[s] != SLOT_IDLE)
				bubble_cells_o[slot_idx_o[s]] = 1'b1;
		end
	end

	// first idle slot of the player, only on a free cell
	always_comb begin
		grant = '0;
		if (p1_req_i && !bubble_cells_o[p1_idx_i]) begin
			if (state[0] == SLOT_IDLE) grant[0] = 1'b1;
			else if (state[1] == SLOT_IDLE) grant[1] = 1'b1;
		end
		p1_grant = grant[0] | grant[1];
		// both players on one cell in the same cycle
		if (p2_req_i && !bubble_cells_o[p2_idx_i] && !(p1_grant && p1_idx_i == p2_idx_i)) begin
			if (state[2] == SLOT_IDLE) grant[2] = 1'b1;
			else if (state[3] == SLOT_IDLE) grant[3] = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int s = 0; s < SLOTS; s++) begin
				state[s] <= SLOT_IDLE;
				timer[s] <= '0;
			end
		end else begin
			for (int s = 0; s < SLOTS; s++) begin
				case (state[s])
					SLOT_IDLE: if (grant[s]) begin
						state[s] <= SLOT_FUSE;
						timer[s] <= TIMER_W'(FUSE_CYCLES - 1);
					end
					// fuse ends or another blast reaches the bubble
					SLOT_FUSE: if (timer[s] == '0 || blast_cells_i[slot_idx_o[s]]) begin
						state[s] <= SLOT_BLAST;
						timer[s] <= TIMER_W'(BLAST_CYCLES - 1);
					end else begin
						timer[s] <= timer[s] - 1'b1;
					end
					SLOT_BLAST: if (timer[s] == '0) state[s] <= SLOT_IDLE;
						else timer[s] <= timer[s] - 1'b1;
					default: state[s] <= SLOT_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < SLOTS; s++)
			if (grant[s])
				slot_idx_o[s] <= (s < 2) ? p1_idx_i : p2_idx_i;
	end

	for (genvar a = 0; a < SLOTS; a++) begin : g_chk_a
		for (genvar b = a + 1; b < SLOTS; b++) begin : g_chk_b
			assert property (@(posedge clk) disable iff (rst)
				!(state[a] != SLOT_IDLE && state[b] != SLOT_IDLE && slot_idx_o[a] == slot_idx_o[b]))
				else $error("slots %0d and %0d share a cell", a, b);
		end
	end

endmodule

// ==== source/player_ctrl.sv ====
`timescale 1ns/1ns

module player_ctrl
	import bomber_pkg::*;
#(
	parameter int START_COL = 0,
	parameter int START_ROW = 0
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             cmd_valid_i,
	input  cmd_op_t          cmd_op_i,
	input  cell_t            target_cell_i,
	input  logic             in_blast_i,
	output logic [IDX_W-1:0] target_idx_o,
	output logic [IDX_W-1:0] cell_idx_o,
	output logic [COL_W-1:0] col_o,
	output logic [ROW_W-1:0] row_o,
	output logic             bubble_req_o,
	output logic             dead_o
);

	logic [COL_W-1:0] next_col;
	logic [ROW_W-1:0] next_row;
	logic             is_move;
	logic             at_edge;
	logic             move_ok;
	logic [$clog2(DEAD_CYCLES):0] dead_cnt;

	// neighbour in the commanded direction
	always_comb begin
		next_col = col_o;
		next_row = row_o;
		is_move  = 1'b1;
		at_edge  = 1'b0;
		case (cmd_op_i)
			OP_UP:    if (row_o == '0) at_edge = 1'b1; else next_row = row_o - 1'b1;
			OP_DOWN:  if (row_o == ROW_W'(GRID_H - 1)) at_edge = 1'b1; else next_row = row_o + 1'b1;
			OP_LEFT:  if (col_o == '0) at_edge = 1'b1; else next_col = col_o - 1'b1;
			OP_RIGHT: if (col_o == COL_W'(GRID_W - 1)) at_edge = 1'b1; else next_col = col_o + 1'b1;
			default:  is_move = 1'b0;
		endcase
	end

	assign target_idx_o = IDX_W'(next_row * GRID_W + next_col);
	assign cell_idx_o   = IDX_W'(row_o * GRID_W + col_o);
	assign move_ok = is_move && !at_edge &&
	                 (target_cell_i == CELL_FLOOR || target_cell_i == CELL_BLAST);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			col_o        <= COL_W'(START_COL);
			row_o        <= ROW_W'(START_ROW);
			bubble_req_o <= 1'b0;
			dead_o       <= 1'b0;
			dead_cnt     <= '0;
		end else begin
			bubble_req_o <= cmd_valid_i && !dead_o && cmd_op_i == OP_BUBBLE;
			if (cmd_valid_i && !dead_o && move_ok) begin
				col_o <= next_col;
				row_o <= next_row;
			end
			// consecutive cycles in blast
			if (!dead_o) begin
				if (!in_blast_i)
					dead_cnt <= '0;
				else if (dead_cnt == DEAD_CYCLES - 1)
					dead_o <= 1'b1;
				else
					dead_cnt <= dead_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== src.f ====
+incdir+test
source/bomber_pkg.sv
source/arena_map.sv
source/player_ctrl.sv
source/bubble_slots.sv
source/blast_spread.sv
source/apb_regs.sv
source/bomber_top.sv
test/tb_bomber.sv

// ==== test/tb_apb_tasks.svh ====
// ----------------------------------------
// APB host side
// ----------------------------------------
localparam int APB_TIMEOUT = 16;

// one transfer, returns in the access phase with the response sampled
// the bus stays in access until the next transfer or release_bus
task automatic bus_transfer(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
	output logic [31:0] rdata, output logic err);
	int waited;
	@(posedge clk);
	paddr   <= addr;
	pwrite  <= wr;
	pwdata  <= wdata;
	psel    <= 1'b1;
	penable <= 1'b0;
	@(posedge clk);
	penable <= 1'b1;
	@(negedge clk);
	waited = 0;
	while (!pready && waited < APB_TIMEOUT) begin
		@(negedge clk);
		waited++;
	end
	if (!pready) begin
		errors++;
		$display("APB transfer to address %h never got pready", addr);
	end
	rdata = prdata;
	err   = pslverr;
endtask

task automatic write_reg(input logic [11:0] addr, input logic [31:0] data, output logic err);
	logic [31:0] unused;
	bus_transfer(addr, 1'b1, data, unused, err);
endtask

task automatic read_reg(input logic [11:0] addr, output logic [31:0] data, output logic err);
	bus_transfer(addr, 1'b0, 32'd0, data, err);
endtask

task automatic release_bus();
	@(posedge clk);
	psel    <= 1'b0;
	penable <= 1'b0;
endtask

// walls where row and column are both odd
function automatic cell_t layout_rule(input int col, input int row);
	if (row % 2 == 1 && col % 2 == 1)
		return CELL_WALL;
	// boxes fill columns 5 and 6
	if (col == 5 || col == 6)
		return CELL_BOX;
	return CELL_FLOOR;
endfunction

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// ==== test/tb_bomber.sv ====
`timescale 1ns/1ns

module tb_bomber
	import bomber_pkg::*;
();

	logic        clk;
	logic        rst;
	logic [11:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	int tests;
	int checks;
	int errors;
	int test_base;

	// reference state of player 1 and the terrain
	cell_t       model [CELL_COUNT];
	logic        blast [CELL_COUNT];
	int          m_col;
	int          m_row;
	int          m_live;
	logic        m_dead;
	logic [15:0] lfsr;

	`include "tb_apb_tasks.svh"

	always #20 clk = ~clk;

	bomber_top DUT (
		.clk, .rst, .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
	);

	function automatic int cell_at(input int col, input int row);
		return row * GRID_W + col;
	endfunction

	function automatic logic [11:0] map_addr(input int idx);
		return ADDR_MAP_BASE + 12'(4 * idx);
	endfunction

	function automatic logic [31:0] pos_word(input int col, input int row);
		return 32'(row * 256 + col);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		assert (got === want)
		else begin
			errors++;
			$display("** Error: %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic read_check(input string name, input logic [11:0] addr, input logic [31:0] want);
		logic [31:0] rd;
		logic        err;
		read_reg(addr, rd, err);
		check_value({name, " pslverr_o"}, 32'(err), 32'd0);
		check_value({name, " prdata_o"}, rd, want);
	endtask

	// poll a register until it holds the wanted value
	task automatic wait_value(input string name, input logic [11:0] addr, input logic [31:0] want,
		input int limit);
		logic [31:0] rd;
		logic        err;
		int          n;
		n  = 0;
		rd = ~want;
		while (rd !== want && n < limit) begin
			read_reg(addr, rd, err);
			n++;
		end
		checks++;
		assert (rd === want)
		else begin
			errors++;
			$display("%s did not reach %h within %0d reads", name, want, limit);
		end
	endtask

	task automatic move_p1(input cmd_op_t op);
		logic err;
		int   c;
		int   r;
		c = m_col;
		r = m_row;
		case (op)
			OP_UP:   r--;
			OP_DOWN: r++;
			OP_LEFT: c--;
			default: c++;
		endcase
		// only plain floor inside the grid takes a live player
		if (!m_dead && c >= 0 && c < GRID_W && r >= 0 && r < GRID_H &&
		    model[cell_at(c, r)] == CELL_FLOOR) begin
			m_col = c;
			m_row = r;
		end
		write_reg(ADDR_CMD, 32'(op), err);
		check_value("CMD pslverr_o", 32'(err), 32'd0);
		read_check("P1_POS", ADDR_P1_POS, pos_word(m_col, m_row));
	endtask

	task automatic drop_p1();
		logic err;
		int   n;
		n = cell_at(m_col, m_row);
		if (!m_dead && m_live < 2 && model[n] != CELL_BUBBLE) begin
			model[n] = CELL_BUBBLE;
			m_live++;
		end
		write_reg(ADDR_CMD, 32'(OP_BUBBLE), err);
		check_value("CMD pslverr_o", 32'(err), 32'd0);
	endtask

	// expected cross of one bubble over the current terrain
	task automatic add_cross(input int col, input int row);
		int c;
		int r;
		bit open;
		blast[cell_at(col, row)] = 1'b1;
		for (int d = 0; d < 4; d++) begin
			c    = col;
			r    = row;
			open = 1'b1;
			for (int k = 0; k < BLAST_RANGE; k++) begin
				case (d)
					0:       r--;
					1:       r++;
					2:       c--;
					default: c++;
				endcase
				if (c < 0 || c >= GRID_W || r < 0 || r >= GRID_H)
					open = 1'b0;
				else if (model[cell_at(c, r)] == CELL_WALL)
					open = 1'b0;
				else if (open) begin
					blast[cell_at(c, r)] = 1'b1;
					open = (model[cell_at(c, r)] != CELL_BOX);
				end
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_base)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - test_base);
		test_base = errors;
	endtask

	initial begin
		logic [31:0] rd;
		logic        err;
		logic [1:0]  dir;
		int          probe [7];
		clk       = 1'b0;
		rst       = 1'b1;
		paddr     = '0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		pwdata    = '0;
		tests     = 0;
		checks    = 0;
		errors    = 0;
		test_base = 0;
		m_col     = 0;
		m_row     = 0;
		m_live    = 0;
		m_dead    = 1'b0;
		lfsr      = 16'd10;
		for (int r = 0; r < GRID_H; r++)
			for (int c = 0; c < GRID_W; c++)
				model[cell_at(c, r)] = layout_rule(c, r);
		for (int n = 0; n < CELL_COUNT; n++)
			blast[n] = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		for (int n = 0; n < CELL_COUNT; n++)
			read_check($sformatf("map[%0d]", n), map_addr(n), 32'(model[n]));
		read_check("STATUS", ADDR_STATUS, 32'd0);
		read_check("P1_POS", ADDR_P1_POS, pos_word(0, 0));
		read_check("P2_POS", ADDR_P2_POS, pos_word(GRID_W - 1, GRID_H - 1));
		finish_test("reset state");

		// two lfsr bits per move pick the direction
		for (int i = 0; i < 32; i++) begin
			for (int b = 0; b < 2; b++) begin
				dir  = {dir[0], lfsr[15]};
				lfsr = lfsr_step(lfsr);
			end
			move_p1(cmd_op_t'(dir));
		end
		finish_test("random moves");

		// back to the corner, then out to column 4
		if (m_row % 2 == 1)
			move_p1(OP_UP);
		repeat (GRID_W) if (m_col > 0) move_p1(OP_LEFT);
		repeat (GRID_H) if (m_row > 0) move_p1(OP_UP);
		repeat (4) move_p1(OP_RIGHT);
		drop_p1();
		wait_value("map[4,0]", map_addr(cell_at(4, 0)), 32'(CELL_BUBBLE), 8);
		move_p1(OP_DOWN);
		drop_p1();
		wait_value("map[4,1]", map_addr(cell_at(4, 1)), 32'(CELL_BUBBLE), 8);
		move_p1(OP_DOWN);
		drop_p1();
		move_p1(OP_UP);
		read_check("map[4,2]", map_addr(cell_at(4, 2)), 32'(model[cell_at(4, 2)]));
		// column 2 of row 2 is outside both crosses
		move_p1(OP_LEFT);
		move_p1(OP_LEFT);
		finish_test("bubble drops");

		// lower bubble is set off by the upper one
		add_cross(4, 0);
		add_cross(4, 1);
		wait_value("map[4,0]", map_addr(cell_at(4, 0)), 32'(CELL_BLAST), 60);
		// col,row 4,3 4,2 2,0 5,0 6,0 2,1 4,4
		probe = '{40, 28, 2, 5, 6, 14, 52};
		foreach (probe[i])
			read_check($sformatf("map[%0d]", probe[i]), map_addr(probe[i]),
				blast[probe[i]] ? 32'(CELL_BLAST) : 32'(model[probe[i]]));
		wait_value("map[4,0]", map_addr(cell_at(4, 0)), 32'(CELL_FLOOR), 40);
		for (int n = 0; n < CELL_COUNT; n++)
			if (model[n] == CELL_BUBBLE || (blast[n] && model[n] == CELL_BOX))
				model[n] = CELL_FLOOR;
		m_live = 0;
		for (int n = 0; n < CELL_COUNT; n++) begin
			if (blast[n])
				read_check($sformatf("map[%0d]", n), map_addr(n), 32'(model[n]));
			blast[n] = 1'b0;
		end
		finish_test("blast and clear");

		drop_p1();
		wait_value("map[2,2]", map_addr(cell_at(2, 2)), 32'(CELL_BUBBLE), 8);
		move_p1(OP_RIGHT);
		wait_value("STATUS", ADDR_STATUS, 32'd1, 80);
		m_dead = 1'b1;
		move_p1(OP_RIGHT);
		move_p1(OP_LEFT);
		finish_test("player death");

		read_reg(12'h010, rd, err);
		check_value("unmapped read pslverr_o", 32'(err), 32'd1);
		read_reg(ADDR_CMD, rd, err);
		check_value("CMD read pslverr_o", 32'(err), 32'd1);
		write_reg(ADDR_STATUS, 32'h3, err);
		check_value("STATUS write pslverr_o", 32'(err), 32'd1);
		read_check("STATUS", ADDR_STATUS, 32'd1);
		finish_test("bus errors");

		release_bus();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
